// ==== cam_lut/lookup_pipeline.sv ====
`timescale 1ns/1ps

module lookup_pipeline import cam_lut_pkg::*; #(
   parameter int  lut_depth = 16,
   localparam int idx_width = $clog2(lut_depth)
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 lookup_req,
   output logic                 lookup_ack,
   output logic                 lookup_hit,
   output lut_data_t            lookup_data,
   output logic [idx_width-1:0] lookup_index,
   output logic                 cam_ready,
   // match array
   input  logic [lut_depth-1:0] match_vec,
   output logic                 array_we,
   output logic [idx_width-1:0] array_index,
   output key_t                 array_cmp,
   output key_t                 array_dmask,
   // indirect access
   input  logic                 rd_req,
   input  logic [idx_width-1:0] rd_index,
   output logic                 rd_ack,
   output lut_data_t            rd_data,
   output key_t                 rd_cmp,
   output key_t                 rd_dmask,
   input  logic                 wr_req,
   input  logic [idx_width-1:0] wr_index,
   output logic                 wr_ack,
   input  lut_data_t            wr_data,
   input  key_t                 wr_cmp,
   input  key_t                 wr_dmask
);

   localparam logic [idx_width-1:0] last_index = idx_width'(lut_depth - 1);

   lut_state_t           state;
   logic                 sweep_we;
   logic [idx_width-1:0] sweep_index;

   logic                 s1_valid;     // stage 1, key sent to the array
   logic                 s2_valid;     // stage 2, match vector held
   logic                 s2_hit;
   logic [lut_depth-1:0] s2_vec;
   logic                 s3_valid;     // stage 3, table read address set
   logic                 s3_hit;
   logic [idx_width-1:0] enc_index;
   logic [idx_width-1:0] lut_rd_index;
   logic                 rd_take;
   logic                 rd_latched;
   logic                 wr_grant;

   lut_data_t            lut_data  [lut_depth];
   key_t                 lut_cmp   [lut_depth];
   key_t                 lut_dmask [lut_depth];
   lut_data_t            q_data;
   key_t                 q_cmp;
   key_t                 q_dmask;

   //////////////////////////////////////////////////////////////////////
   // init sweep, one entry per cycle
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= st_init;
         sweep_we    <= 1'b0;
         sweep_index <= '0;
      end else if (state == st_init) begin
         sweep_we <= 1'b1;
         if (sweep_we) begin
            if (sweep_index == last_index) begin
               state    <= st_ready;
               sweep_we <= 1'b0;
            end else begin
               sweep_index <= sweep_index + 1'b1;
            end
         end
      end
   end

   assign cam_ready = (state == st_ready);

   // write only into an empty pipe so table and array stay in step
   assign wr_grant    = cam_ready & wr_req & ~lookup_req & ~s1_valid & ~s2_valid & ~s3_valid;
   assign wr_ack      = wr_grant;
   assign array_we    = sweep_we | wr_grant;
   assign array_index = cam_ready ? wr_index : sweep_index;
   assign array_cmp   = cam_ready ? wr_cmp : '0;
   assign array_dmask = cam_ready ? wr_dmask : '0;

   always_ff @(posedge clk) begin
      if (array_we) begin
         lut_data[array_index]  <= cam_ready ? wr_data : '0;
         lut_cmp[array_index]   <= array_cmp;
         lut_dmask[array_index] <= array_dmask;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // lookup stages
   //////////////////////////////////////////////////////////////////////

   // lowest index wins
   always_comb begin
      enc_index = last_index;
      for (int i = lut_depth - 1; i >= 0; i--) begin
         if (s2_vec[i])
            enc_index = idx_width'(i);
      end
   end

   // reads borrow the table port when no hit needs it, one at a time
   assign rd_take = rd_req & ~s2_hit & ~rd_latched & ~rd_ack;

   always_ff @(posedge clk) begin
      if (reset) begin
         s1_valid   <= 1'b0;
         s2_valid   <= 1'b0;
         s2_hit     <= 1'b0;
         s3_valid   <= 1'b0;
         s3_hit     <= 1'b0;
         rd_latched <= 1'b0;
         lookup_ack <= 1'b0;
         lookup_hit <= 1'b0;
         rd_ack     <= 1'b0;
      end else begin
         s1_valid   <= lookup_req & cam_ready;   // requests dropped during the sweep
         s2_valid   <= s1_valid;
         s2_hit     <= s1_valid & |match_vec;
         s3_valid   <= s2_valid;
         s3_hit     <= s2_hit;
         rd_latched <= rd_take;
         lookup_ack <= s3_valid;
         lookup_hit <= s3_hit;
         rd_ack     <= rd_latched;
      end
   end

   always_ff @(posedge clk) begin
      s2_vec       <= match_vec;
      lut_rd_index <= rd_take ? rd_index : enc_index;
      q_data       <= lut_data[lut_rd_index];
      q_cmp        <= lut_cmp[lut_rd_index];
      q_dmask      <= lut_dmask[lut_rd_index];
      lookup_index <= lut_rd_index;
   end

   assign lookup_data = lookup_hit ? q_data : '0;   // zero on a miss
   assign rd_data     = q_data;
   assign rd_cmp      = q_cmp;
   assign rd_dmask    = q_dmask;

endmodule

// ==== cam_lut/tcam_array.sv ====
`timescale 1ns/1ps

module tcam_array import cam_lut_pkg::*; #(
   parameter int  lut_depth = 16,
   localparam int idx_width = $clog2(lut_depth)
) (
   input  logic                 clk,
   // key under test
   input  key_t                 lookup_cmp,
   input  key_t                 lookup_dmask,
   output logic [lut_depth-1:0] match_vec,
   // entry update
   input  logic                 array_we,
   input  logic [idx_width-1:0] array_index,
   input  key_t                 array_cmp,
   input  key_t                 array_dmask
);

   key_t                 cmp_mem   [lut_depth];
   key_t                 dmask_mem [lut_depth];
   logic [lut_depth-1:0] match_next;

   //////////////////////////////////////////////////////////////////////
   // entry storage
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (array_we) begin
         cmp_mem[array_index]   <= array_cmp;
         dmask_mem[array_index] <= array_dmask;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // ternary compare
   //////////////////////////////////////////////////////////////////////

   // a set bit in either mask removes that bit from the compare
   always_comb begin
      for (int i = 0; i < lut_depth; i++) begin
         match_next[i] = ~|((lookup_cmp ^ cmp_mem[i]) & ~(lookup_dmask | dmask_mem[i]));
      end
   end

   always_ff @(posedge clk) begin
      match_vec <= match_next;   // one bit per entry, not encoded
   end

endmodule

// ==== cam_lut_top.f ====
common/cam_lut_pkg.sv
common/reg_ring_pkg.sv
cam_lut/tcam_array.sv
cam_lut/lookup_pipeline.sv
source/cam_lut_regs.sv
source/cam_lut_top.sv
tests/tb_cam_lut_asserts.sv
tests/tb_cam_lut.sv

// ==== common/cam_lut_pkg.sv ====
package cam_lut_pkg;

   ////////////////////////////////////////////////////////////////////
   // table widths
   ////////////////////////////////////////////////////////////////////

   localparam int key_width  = 32;   // compare word and masks
   localparam int data_width = 32;   // result word per entry

   ////////////////////////////////////////////////////////////////////
   // types
   ////////////////////////////////////////////////////////////////////

   typedef logic [key_width-1:0]  key_t;        // compare word or don't-care mask
   typedef logic [data_width-1:0] lut_data_t;   // result table word

   // lookup controller: sweep all entries, then serve lookups
   typedef enum logic {
      st_init,
      st_ready
   } lut_state_t;

endpackage

// ==== common/reg_ring_pkg.sv ====
package reg_ring_pkg;

   ////////////////////////////////////////////////////////////////////
   // ring word fields
   ////////////////////////////////////////////////////////////////////

   localparam int ring_addr_width  = 12;
   localparam int block_addr_width = 5;    // register offset inside a block
   localparam int tag_width        = ring_addr_width - block_addr_width;
   localparam int ring_data_width  = 32;
   localparam int ring_src_width   = 2;

   typedef logic [ring_addr_width-1:0] ring_addr_t;
   typedef logic [ring_data_width-1:0] ring_data_t;
   typedef logic [ring_src_width-1:0]  ring_src_t;   // which master started the access
   typedef logic [tag_width-1:0]       tag_t;

   // register map of the lookup block
   typedef enum logic [2:0] {
      reg_entry_data  = 3'd0,
      reg_entry_dmask = 3'd1,
      reg_entry_cmp   = 3'd2,
      reg_read_index  = 3'd3,   // write here to fetch an entry
      reg_write_index = 3'd4    // write here to store an entry
   } reg_index_t;

   localparam logic [block_addr_width-1:0] num_regs = 5'd5;

   typedef enum logic [1:0] {wait_request, wait_read, wait_write} reg_state_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# build the cam_lut testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_cam_lut -f cam_lut_top.f -o sim_cam_lut

result=$(./obj_dir/sim_cam_lut) || true
echo "$result"

if echo "$result" | grep -q "Everything OK"; then
   exit 0
fi
exit 1

// ==== source/cam_lut_regs.sv ====
`timescale 1ns/1ps

module cam_lut_regs import reg_ring_pkg::*, cam_lut_pkg::*; #(
   parameter int   lut_depth = 16,
   parameter tag_t tag       = 7'h2a,
   localparam int  idx_width = $clog2(lut_depth)
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 ring_req,
   input  logic                 ring_ack,
   input  logic                 ring_rd_wr_l,
   input  ring_addr_t           ring_addr,
   input  ring_data_t           ring_data,
   input  ring_src_t            ring_src,
   output logic                 fwd_req,
   output logic                 fwd_ack,
   output logic                 fwd_rd_wr_l,
   output ring_addr_t           fwd_addr,
   output ring_data_t           fwd_data,
   output ring_src_t            fwd_src,
   // indirect entry access
   output logic                 rd_req,
   output logic [idx_width-1:0] rd_index,
   input  logic                 rd_ack,
   input  lut_data_t            rd_data,
   input  key_t                 rd_cmp,
   input  key_t                 rd_dmask,
   output logic                 wr_req,
   output logic [idx_width-1:0] wr_index,
   input  logic                 wr_ack,
   output lut_data_t            wr_data,
   output key_t                 wr_cmp,
   output key_t                 wr_dmask
);

   reg_state_t                  state;
   ring_data_t                  reg_file [num_regs];   // staging registers

   tag_t                        addr_tag;
   logic [block_addr_width-1:0] blk_addr;
   reg_index_t                  reg_sel;
   logic                        ours;
   logic                        indirect;

   //////////////////////////////////////////////////////////////////////
   // address decode
   //////////////////////////////////////////////////////////////////////

   assign addr_tag = ring_addr[ring_addr_width-1:block_addr_width];
   assign blk_addr = ring_addr[block_addr_width-1:0];
   assign reg_sel  = reg_index_t'(blk_addr[2:0]);

   assign ours     = ring_req && (addr_tag == tag) && (blk_addr < num_regs);
   // writes to either index register start a table access
   assign indirect = !ring_rd_wr_l &&
                     (reg_sel == reg_read_index || reg_sel == reg_write_index);

   // entry contents come straight from the staging registers
   assign wr_data  = reg_file[reg_entry_data];
   assign wr_dmask = reg_file[reg_entry_dmask];
   assign wr_cmp   = reg_file[reg_entry_cmp];
   assign rd_index = reg_file[reg_read_index][idx_width-1:0];
   assign wr_index = reg_file[reg_write_index][idx_width-1:0];

   //////////////////////////////////////////////////////////////////////
   // ring handling and indirect access controller
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= wait_request;
         fwd_req <= 1'b0;
         fwd_ack <= 1'b0;
         rd_req  <= 1'b0;
         wr_req  <= 1'b0;
      end else begin
         fwd_req <= 1'b0;
         fwd_ack <= 1'b0;
         case (state)
            wait_request: begin
               fwd_rd_wr_l <= ring_rd_wr_l;
               fwd_addr    <= ring_addr;
               fwd_src     <= ring_src;
               fwd_data    <= ring_data;
               if (!ours) begin                  // not for us, pass along
                  fwd_req <= ring_req;
                  fwd_ack <= ring_ack;
               end else if (indirect) begin
                  reg_file[reg_sel] <= ring_data;   // answer comes when the table is done
                  if (reg_sel == reg_read_index) begin
                     rd_req <= 1'b1;
                     state  <= wait_read;
                  end else begin
                     wr_req <= 1'b1;
                     state  <= wait_write;
                  end
               end else begin
                  fwd_req <= 1'b1;
                  fwd_ack <= 1'b1;
                  if (ring_rd_wr_l)
                     fwd_data <= reg_file[reg_sel];
                  else
                     reg_file[reg_sel] <= ring_data;
               end
            end
            wait_read: begin
               if (rd_ack) begin
                  rd_req                    <= 1'b0;
                  fwd_req                   <= 1'b1;
                  fwd_ack                   <= 1'b1;
                  reg_file[reg_entry_data]  <= rd_data;
                  reg_file[reg_entry_dmask] <= rd_dmask;
                  reg_file[reg_entry_cmp]   <= rd_cmp;
                  state                     <= wait_request;
               end
            end
            wait_write: begin
               if (wr_ack) begin
                  wr_req  <= 1'b0;
                  fwd_req <= 1'b1;
                  fwd_ack <= 1'b1;
                  state   <= wait_request;
               end
            end
            default: state <= wait_request;
         endcase
      end
   end

endmodule

// ==== source/cam_lut_top.sv ====
`timescale 1ns/1ps

module cam_lut_top import cam_lut_pkg::*, reg_ring_pkg::*; #(
   parameter int   lut_depth = 16,
   parameter tag_t tag       = 7'h2a,
   localparam int  idx_width = $clog2(lut_depth)
) (
   input  logic                 clk,
   input  logic                 reset,
   // lookups
   input  logic                 lookup_req,
   input  key_t                 lookup_cmp,
   input  key_t                 lookup_dmask,
   output logic                 lookup_ack,
   output logic                 lookup_hit,
   output lut_data_t            lookup_data,
   output logic [idx_width-1:0] lookup_index,
   output logic                 cam_ready,
   // register ring in
   input  logic                 ring_req,
   input  logic                 ring_ack,
   input  logic                 ring_rd_wr_l,
   input  ring_addr_t           ring_addr,
   input  ring_data_t           ring_data,
   input  ring_src_t            ring_src,
   // register ring out
   output logic                 fwd_req,
   output logic                 fwd_ack,
   output logic                 fwd_rd_wr_l,
   output ring_addr_t           fwd_addr,
   output ring_data_t           fwd_data,
   output ring_src_t            fwd_src
);

   logic                 rd_req;
   logic [idx_width-1:0] rd_index;
   logic                 rd_ack;
   lut_data_t            rd_data;
   key_t                 rd_cmp;
   key_t                 rd_dmask;
   logic                 wr_req;
   logic [idx_width-1:0] wr_index;
   logic                 wr_ack;
   lut_data_t            wr_data;
   key_t                 wr_cmp;
   key_t                 wr_dmask;

   logic [lut_depth-1:0] match_vec;
   logic                 array_we;
   logic [idx_width-1:0] array_index;
   key_t                 array_cmp;
   key_t                 array_dmask;

   cam_lut_regs #(.lut_depth(lut_depth), .tag(tag)) i_regs (.*);   // ring side

   lookup_pipeline #(.lut_depth(lut_depth)) i_pipe (.*);           // lookup stages and table

   tcam_array #(.lut_depth(lut_depth)) i_tcam (.*);                // ternary compare

endmodule

// ==== tests/tb_cam_lut.sv ====
`timescale 1ns/1ps

module tb_cam_lut import cam_lut_pkg::*, reg_ring_pkg::*; ();

   localparam int   lut_depth = 16;
   localparam int   idx_width = $clog2(lut_depth);
   localparam tag_t our_tag   = 7'h2a;
   localparam int   max_wait  = 64;   // cycles allowed for any single wait

   logic                 clk = 1'b0;
   logic                 reset;
   logic                 lookup_req;
   key_t                 lookup_cmp;
   key_t                 lookup_dmask;
   logic                 lookup_ack;
   logic                 lookup_hit;
   lut_data_t            lookup_data;
   logic [idx_width-1:0] lookup_index;
   logic                 cam_ready;
   logic                 ring_req;
   logic                 ring_ack;
   logic                 ring_rd_wr_l;
   ring_addr_t           ring_addr;
   ring_data_t           ring_data;
   ring_src_t            ring_src;
   logic                 fwd_req;
   logic                 fwd_ack;
   logic                 fwd_rd_wr_l;
   ring_addr_t           fwd_addr;
   ring_data_t           fwd_data;
   ring_src_t            fwd_src;

   key_t        model_cmp   [lut_depth];   // expected table contents
   key_t        model_dmask [lut_depth];
   lut_data_t   model_data  [lut_depth];
   logic [31:0] lfsr = 32'h8eeb;
   string       test_name;
   int          errors = 0;
   int          checks = 0;
   int          tests_run = 0;
   int          errors_before;

   cam_lut_top #(.lut_depth(lut_depth), .tag(our_tag)) i_dut (.*);

   always #20 clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] random_bits(input int count);
      logic [31:0] value;
      logic        bit_out;
      value = '0;
      for (int i = 0; i < count; i++) begin
         bit_out = lfsr[0];
         lfsr    = (lfsr >> 1) ^ (bit_out ? 32'h8020_0003 : 32'h0);   // galois taps
         value   = {value[30:0], bit_out};
      end
      return value;
   endfunction

   // lowest entry whose unmasked bits all agree with the key or -1 on a miss
   function automatic int expected_index(input key_t key, input key_t mask);
      for (int i = 0; i < lut_depth; i++) begin
         if (((key ^ model_cmp[i]) & ~(mask | model_dmask[i])) == '0)
            return i;
      end
      return -1;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #5;
   endtask

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("ERR %s %s: expected %h, actual %h", test_name, what, expected, actual);
      end
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("%s: %s", test_name, what);
   endtask

   task automatic start_test(input string name);
      test_name     = name;
      errors_before = errors;
   endtask

   task automatic finish_test();
      tests_run++;
      $display("test %s finished with %0d errors", test_name, errors - errors_before);
   endtask

   // one word on the ring, then wait for the block to answer it
   task automatic ring_access(input logic rd_wr_l, input reg_index_t reg_sel,
                              input ring_data_t data, output ring_data_t answer);
      int   cycles;
      logic table_access;
      table_access = !rd_wr_l && (reg_sel == reg_read_index || reg_sel == reg_write_index);
      ring_req     = 1'b1;
      ring_ack     = 1'b0;
      ring_rd_wr_l = rd_wr_l;
      ring_addr    = {our_tag, 5'(reg_sel)};
      ring_data    = data;
      ring_src     = 2'd1;
      cycles       = 0;
      do begin
         next_cycle();
         ring_req = 1'b0;
         cycles++;
      end while (!fwd_ack && cycles < max_wait);
      if (!fwd_ack) begin
         report_failure("no fwd_ack came back for a ring access");
      end else begin
         check_value("answer fields", 32'({1'b1, rd_wr_l, 2'd1, ring_addr}),
                     32'({fwd_req, fwd_rd_wr_l, fwd_src, fwd_addr}));
         if (!table_access)
            check_value("answer latency", 32'd1, 32'(cycles));   // staging registers answer at once
      end
      answer = fwd_data;
   endtask

   task automatic ring_write(input reg_index_t reg_sel, input ring_data_t data);
      ring_data_t ignored;
      ring_access(1'b0, reg_sel, data, ignored);
   endtask

   task automatic ring_read(input reg_index_t reg_sel, output ring_data_t data);
      ring_access(1'b1, reg_sel, '0, data);
   endtask

   // a word that is not ours comes out unchanged one cycle later
   task automatic forward_check(input ring_addr_t addr, input logic ack);
      ring_data_t data;
      data         = random_bits(32);
      ring_req     = 1'b1;
      ring_ack     = ack;
      ring_rd_wr_l = ack;
      ring_addr    = addr;
      ring_data    = data;
      ring_src     = 2'd2;
      next_cycle();
      ring_req = 1'b0;
      ring_ack = 1'b0;
      check_value("forwarded fields", 32'({1'b1, ack, ack, 2'd2, addr}),
                  32'({fwd_req, fwd_ack, fwd_rd_wr_l, fwd_src, fwd_addr}));
      check_value("forwarded data", data, fwd_data);
   endtask

   task automatic write_entry(input int index, input key_t cmp, input key_t dmask,
                              input lut_data_t data);
      ring_write(reg_entry_data, data);
      ring_write(reg_entry_dmask, dmask);
      ring_write(reg_entry_cmp, cmp);
      ring_write(reg_write_index, 32'(index));   // starts the table write
      model_cmp[index]   = cmp;
      model_dmask[index] = dmask;
      model_data[index]  = data;
   endtask

   task automatic check_result(input int exp_index);
      check_value("lookup_hit", 32'(exp_index >= 0), 32'(lookup_hit));
      check_value("lookup_data", exp_index >= 0 ? model_data[exp_index] : 32'h0, lookup_data);
      if (exp_index >= 0)
         check_value("lookup_index", 32'(exp_index), 32'(lookup_index));
   endtask

   task automatic check_lookup(input key_t key, input key_t mask);
      int latency;
      lookup_req   = 1'b1;
      lookup_cmp   = key;
      lookup_dmask = mask;
      latency      = 0;
      do begin
         next_cycle();
         lookup_req = 1'b0;
         latency++;
      end while (!lookup_ack && latency < max_wait);
      if (!lookup_ack)
         report_failure("a lookup was never acknowledged");
      check_value("ack latency", 32'd4, 32'(latency));   // edge 4 counting the sampling edge
      check_result(expected_index(key, mask));
   endtask

   //////////////////////////////////////////////////////////////////////
   // tests
   //////////////////////////////////////////////////////////////////////

   task automatic reset_and_ready();
      int cycles;
      start_test("reset_and_ready");
      check_value("fwd_ack", 32'd0, 32'(fwd_ack));
      check_value("lookup_ack", 32'd0, 32'(lookup_ack));
      cycles = 0;
      while (!cam_ready && cycles < max_wait) begin
         next_cycle();
         cycles++;
      end
      if (!cam_ready)
         report_failure("cam_ready never came up after reset");
      check_lookup(32'h0000_0001, '0);   // misses the swept table
      check_lookup(32'h0, '0);           // hits entry 0 with data 0
      finish_test();
   endtask

   task automatic staging_and_forwarding();
      reg_index_t staged [3] = '{reg_entry_data, reg_entry_dmask, reg_entry_cmp};
      ring_data_t value;
      ring_data_t back;
      start_test("staging_and_forwarding");
      foreach (staged[i]) begin
         value = random_bits(32);
         ring_write(staged[i], value);
         ring_read(staged[i], back);
         check_value("staging readback", value, back);
      end
      forward_check({7'h15, 5'd2}, 1'b1);     // foreign tag
      forward_check({our_tag, 5'd5}, 1'b0);   // first address past the map
      forward_check({our_tag, 5'd31}, 1'b1);
      finish_test();
   endtask

   task automatic indirect_writes();
      start_test("indirect_writes");
      write_entry(3, 32'hcafe_0000, 32'h0000_ffff, 32'h1111_0003);
      write_entry(5, 32'h1234_5678, 32'h0, 32'h5555_0005);
      write_entry(9, 32'hdead_beef, 32'h0, 32'h9999_0009);
      check_lookup(32'hcafe_1234, '0);
      check_lookup(32'h1234_5678, '0);
      check_lookup(32'hdead_be00, 32'h0000_00ff);   // low byte ignored by the key
      check_lookup(32'h0bad_f00d, '0);
      finish_test();
   endtask

   task automatic overlapping_masks();
      key_t base;
      key_t span;
      key_t key;
      key_t mask;
      start_test("overlapping_masks");
      base = random_bits(32);
      write_entry(10, base, 32'h0000_000f, random_bits(32));
      write_entry(11, base, 32'h0000_00ff, random_bits(32));
      write_entry(12, base ^ 32'h0000_0100, 32'h0000_ffff, random_bits(32));
      write_entry(13, 32'h0, 32'hffff_ffff, random_bits(32));   // catches every key
      for (int i = 0; i < 16; i++) begin
         case (i % 4)
            0:       span = 32'h0000_000f;
            1:       span = 32'h0000_00ff;
            2:       span = 32'h0000_0fff;
            default: span = 32'hffff_ffff;
         endcase
         key  = base ^ (random_bits(32) & span);
         mask = (i % 3 == 0) ? random_bits(8) : '0;
         check_lookup(key, mask);
      end
      finish_test();
   endtask

   task automatic indirect_reads();
      int         entries [3] = '{5, 12, 3};
      ring_data_t value;
      start_test("indirect_reads");
      foreach (entries[i]) begin
         ring_write(reg_read_index, 32'(entries[i]));   // loads the staging registers
         ring_read(reg_entry_data, value);
         check_value("entry data", model_data[entries[i]], value);
         ring_read(reg_entry_dmask, value);
         check_value("entry dmask", model_dmask[entries[i]], value);
         ring_read(reg_entry_cmp, value);
         check_value("entry cmp", model_cmp[entries[i]], value);
      end
      finish_test();
   endtask

   task automatic back_to_back_lookups();
      key_t keys [8];
      int   sent;
      int   acked;
      int   cycles;
      start_test("back_to_back_lookups");
      foreach (keys[i])
         keys[i] = (i % 2 == 0) ? model_cmp[3 + 3 * (i / 2)] ^ random_bits(4) : random_bits(32);
      sent         = 0;
      acked        = 0;
      cycles       = 0;
      lookup_dmask = '0;
      while (acked < 8 && cycles < max_wait) begin
         if (sent < 8) begin
            lookup_req = 1'b1;
            lookup_cmp = keys[sent];
            sent++;
         end else begin
            lookup_req = 1'b0;
         end
         next_cycle();
         cycles++;
         if (lookup_ack) begin   // results return in request order
            check_result(expected_index(keys[acked], '0));
            acked++;
         end
      end
      lookup_req = 1'b0;
      if (acked != 8)
         report_failure("not every back to back lookup was acknowledged");
      finish_test();
   endtask

   initial begin
      reset        = 1'b1;
      lookup_req   = 1'b0;
      lookup_cmp   = '0;
      lookup_dmask = '0;
      ring_req     = 1'b0;
      ring_ack     = 1'b0;
      ring_rd_wr_l = 1'b1;
      ring_addr    = '0;
      ring_data    = '0;
      ring_src     = '0;
      for (int i = 0; i < lut_depth; i++) begin   // the sweep clears every entry
         model_cmp[i]   = '0;
         model_dmask[i] = '0;
         model_data[i]  = '0;
      end
      repeat (4) @(posedge clk);
      #5;
      reset = 1'b0;
      reset_and_ready();
      staging_and_forwarding();
      indirect_writes();
      overlapping_masks();
      indirect_reads();
      back_to_back_lookups();
      errors += int'(i_dut.i_pipe.i_asserts.failures);
      $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

// ==== tests/tb_cam_lut_asserts.sv ====
`timescale 1ns/1ps

module tb_cam_lut_asserts (
   input logic clk,
   input logic reset,
   input logic cam_ready,
   input logic array_we,
   input logic s1_valid,
   input logic s2_valid,
   input logic s3_valid,
   input logic lookup_ack,
   input logic lookup_hit
);

   int unsigned failures = 0;   // failed assertions so far

   // a hit is only reported together with its ack
   hit_needs_ack: assert property (@(posedge clk) disable iff (reset)
      lookup_hit |-> lookup_ack)
      else begin
         failures++;
         $error("lookup_hit raised without lookup_ack");
      end

   // entry updates only go into an empty pipe
   write_into_empty_pipe: assert property (@(posedge clk) disable iff (reset)
      (cam_ready && array_we) |-> !(s1_valid || s2_valid || s3_valid))
      else begin
         failures++;
         $error("array_we while a lookup is in stages 1 to 3");
      end

   ready_stays_high: assert property (@(posedge clk) disable iff (reset)
      cam_ready |=> cam_ready)   // the sweep runs once per reset
      else begin
         failures++;
         $error("cam_ready fell after it was raised");
      end

endmodule

bind lookup_pipeline tb_cam_lut_asserts i_asserts (
   .clk        (clk),
   .reset      (reset),
   .cam_ready  (cam_ready),
   .array_we   (array_we),
   .s1_valid   (s1_valid),
   .s2_valid   (s2_valid),
   .s3_valid   (s3_valid),
   .lookup_ack (lookup_ack),
   .lookup_hit (lookup_hit)
);
